// ==== all.f ====
design/mmu_pkg.sv
design/dtlb.sv
design/ptw_fsm.sv
design/translate_stage.sv
design/mmu_top.sv
tb/pte_memory.sv
tb/mmu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mmu_tb -f all.f -o mmu_sim

out=$(obj_dir/mmu_sim)
echo "$out"

# the run passes only if the pass line was printed
echo "$out" | grep -qx '>>> PASS'

// ==== tb/mmu_tb.sv ====
// table-driven testbench for the data MMU, run as the simulation top with the page table memory
`timescale 1ns/1ps

module mmu_tb;
    import mmu_pkg::*;

    localparam int NUM_ROWS = 16;
    localparam int TIMEOUT  = 200;

    // one stimulus row with its expected result
    typedef struct packed {
        logic             en;
        priv_lvl_e        priv;
        logic             sum;
        logic             mxr;
        logic             flush;
        logic [31:0]      vaddr;
        logic             is_store;
        logic [PLEN-1:0]  exp_paddr;
        logic             exp_exc;
        exc_cause_e       exp_cause;
        logic             exp_hit;
    } row_t;

    logic              clk_i;
    logic              rst_ni;
    lsu_req_t          lsu_req;
    logic              enable_translation;
    priv_lvl_e         priv_lvl;
    logic              sum;
    logic              mxr;
    logic [PPN_W-1:0]  satp_ppn;
    logic              flush_tlb;
    logic              lsu_dtlb_hit_o;
    logic [PPN_W-1:0]  lsu_dtlb_ppn_o;
    logic              lsu_valid_o;
    logic [PLEN-1:0]   lsu_paddr_o;
    exception_t        lsu_exc_o;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;
    int unsigned       read_count;

    row_t rows [NUM_ROWS];
    int   errors;
    int   test_errors;
    logic timed_out;

    mmu_top #(
        .DTLB_ENTRIES ( 4 )
    ) i_dut (
        .clk_i                ( clk_i              ),
        .rst_ni               ( rst_ni             ),
        .lsu_req_i            ( lsu_req            ),
        .enable_translation_i ( enable_translation ),
        .priv_lvl_i           ( priv_lvl           ),
        .sum_i                ( sum                ),
        .mxr_i                ( mxr                ),
        .satp_ppn_i           ( satp_ppn           ),
        .flush_tlb_i          ( flush_tlb          ),
        .lsu_dtlb_hit_o       ( lsu_dtlb_hit_o     ),
        .lsu_dtlb_ppn_o       ( lsu_dtlb_ppn_o     ),
        .lsu_valid_o          ( lsu_valid_o        ),
        .lsu_paddr_o          ( lsu_paddr_o        ),
        .lsu_exc_o            ( lsu_exc_o          ),
        .apb_req_o            ( apb_req            ),
        .apb_rsp_i            ( apb_rsp            )
    );

    pte_memory i_mem (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .apb_req_i    ( apb_req    ),
        .apb_rsp_o    ( apb_rsp    ),
        .read_count_o ( read_count )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ------------------------------
    // stimulus table
    // ------------------------------
    task automatic load_table();
        // en, priv, sum, mxr, flush, vaddr, st, paddr, exc, cause, hit
        rows[0]  = '{1'b0, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h12345678, 1'b0,
                     34'h012345678, 1'b0, LOAD_PAGE_FAULT, 1'b1};
        rows[1]  = '{1'b1, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h00400abc, 1'b0,
                     34'h300005abc, 1'b0, LOAD_PAGE_FAULT, 1'b0};
        rows[2]  = '{1'b1, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h00400010, 1'b1,
                     34'h300005010, 1'b0, LOAD_PAGE_FAULT, 1'b1};
        rows[3]  = '{1'b1, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h00955123, 1'b0,
                     34'h000555123, 1'b0, LOAD_PAGE_FAULT, 1'b0};
        rows[4]  = '{1'b1, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h00c00000, 1'b0,
                     34'h0, 1'b1, LOAD_PAGE_FAULT, 1'b0};
        rows[5]  = '{1'b1, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h00401004, 1'b0,
                     34'h0, 1'b1, LOAD_PAGE_FAULT, 1'b0};
        rows[6]  = '{1'b1, PRIV_S, 1'b1, 1'b0, 1'b0, 32'h00401004, 1'b0,
                     34'h000022004, 1'b0, LOAD_PAGE_FAULT, 1'b1};
        rows[7]  = '{1'b1, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h00402008, 1'b0,
                     34'h0, 1'b1, LOAD_PAGE_FAULT, 1'b0};
        rows[8]  = '{1'b1, PRIV_S, 1'b0, 1'b1, 1'b0, 32'h00402008, 1'b0,
                     34'h000033008, 1'b0, LOAD_PAGE_FAULT, 1'b1};
        rows[9]  = '{1'b1, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h00403000, 1'b1,
                     34'h0, 1'b1, STORE_PAGE_FAULT, 1'b0};
        rows[10] = '{1'b1, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h00404000, 1'b1,
                     34'h0, 1'b1, STORE_PAGE_FAULT, 1'b0};
        rows[11] = '{1'b1, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h00000100, 1'b0,
                     34'h0, 1'b1, LOAD_PAGE_FAULT, 1'b0};
        rows[12] = '{1'b1, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h01800000, 1'b0,
                     34'h0, 1'b1, LOAD_ACCESS_FAULT, 1'b0};
        rows[13] = '{1'b1, PRIV_S, 1'b0, 1'b0, 1'b0, 32'h01800040, 1'b1,
                     34'h0, 1'b1, STORE_ACCESS_FAULT, 1'b0};
        rows[14] = '{1'b1, PRIV_U, 1'b0, 1'b0, 1'b0, 32'h00401010, 1'b0,
                     34'h000022010, 1'b0, LOAD_PAGE_FAULT, 1'b1};
        // same page right after a flush
        rows[15] = '{1'b1, PRIV_U, 1'b0, 1'b0, 1'b1, 32'h00401010, 1'b0,
                     34'h000022010, 1'b0, LOAD_PAGE_FAULT, 1'b0};
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (exp !== got) begin
            $display("Mismatch at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    // ------------------------------
    // one row, request held until the result
    // ------------------------------
    task automatic run_row(input int t);
        row_t             r;
        int               cycles;
        int unsigned      reads_before;
        logic             hit_seen;
        logic [PPN_W-1:0] ppn_seen;
        logic             done;
        r           = rows[t];
        test_errors = 0;
        @(posedge clk_i);
        #1;
        if (r.flush) begin
            flush_tlb = 1'b1;
            @(posedge clk_i);
            #1;
            flush_tlb = 1'b0;
        end
        enable_translation = r.en;
        priv_lvl           = r.priv;
        sum                = r.sum;
        mxr                = r.mxr;
        lsu_req.vaddr      = r.vaddr;
        lsu_req.is_store   = r.is_store;
        lsu_req.valid      = 1'b1;
        reads_before       = read_count;
        #1;
        hit_seen = lsu_dtlb_hit_o;
        ppn_seen = lsu_dtlb_ppn_o;
        cycles   = 0;
        done     = 1'b0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
            if (lsu_valid_o) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("test %0d: no translation result within %0d cycles", t, TIMEOUT);
            timed_out = 1'b1;
            errors++;
        end else begin
            check_value("lsu_dtlb_hit_o", 64'(r.exp_hit), 64'(hit_seen));
            check_value("lsu_exc_o.valid", 64'(r.exp_exc), 64'(lsu_exc_o.valid));
            if (r.exp_exc) begin
                check_value("lsu_exc_o.cause", 64'(r.exp_cause), 64'(lsu_exc_o.cause));
                check_value("lsu_exc_o.tval", 64'(r.vaddr), 64'(lsu_exc_o.tval));
            end else begin
                check_value("lsu_paddr_o", 64'(r.exp_paddr), 64'(lsu_paddr_o));
            end
            // a hit answers one cycle later and reads no table
            if (r.exp_hit) begin
                // page number of the result is already known in the request cycle
                check_value("lsu_dtlb_ppn_o", 64'(r.exp_paddr[PLEN-1:PAGE_OFFSET_W]),
                            64'(ppn_seen));
                check_value("latency", 64'(1), 64'(cycles));
                check_value("read_count", 64'(reads_before), 64'(read_count));
            end else begin
                check_value("read_count rose", 64'(1), 64'(read_count > reads_before));
            end
        end
        lsu_req.valid = 1'b0;
        $display("test %0d finished after %0d cycles with %0d errors", t, cycles, test_errors);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rst_ni             = 1'b0;
        lsu_req            = '0;
        enable_translation = 1'b0;
        priv_lvl           = PRIV_S;
        sum                = 1'b0;
        mxr                = 1'b0;
        satp_ppn           = 22'h000010;
        flush_tlb          = 1'b0;
        errors             = 0;
        test_errors        = 0;
        timed_out          = 1'b0;
        load_table();
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        for (int t = 0; t < NUM_ROWS && !timed_out; t++) begin
            run_row(t);
        end
        $display("%0d tests, %0d errors", NUM_ROWS, errors);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tb/pte_memory.sv ====
// APB completer model holding the Sv32 page tables for the MMU testbench, with random wait states
`timescale 1ns/1ps

module pte_memory (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  mmu_pkg::apb_req_t   apb_req_i,
    output mmu_pkg::apb_rsp_t   apb_rsp_o,
    output int unsigned         read_count_o
);
    import mmu_pkg::*;

    // 2048 words at 0x10000, root table first, second level table at 0x11000
    logic [31:0] mem [2048];
    logic [1:0]  wait_q;
    logic        in_range;
    logic [10:0] word_idx;
    int          seed;

    function automatic logic [31:0] pte_word(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    // ------------------------------
    // table contents
    // ------------------------------
    initial begin
        seed = 80806;
        // every word holds its own address, so v stays clear by default
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 32'h0001_0000 + 32'(i) * 32'd4;
        end
        // root entries
        mem[1]    = pte_word(22'h000011, 8'h01);
        // megapage, S, rwad
        mem[2]    = pte_word(22'h000400, 8'hc7);
        // megapage with ppn0 set
        mem[3]    = pte_word(22'h000401, 8'h43);
        // pointer to a table outside this memory
        mem[6]    = pte_word(22'h000050, 8'h01);
        // second level entries
        mem[1024] = pte_word(22'h300005, 8'hc7);
        // user page
        mem[1025] = pte_word(22'h000022, 8'hd7);
        // execute only
        mem[1026] = pte_word(22'h000033, 8'h49);
        // read only
        mem[1027] = pte_word(22'h000044, 8'hc3);
        // writable but not dirty
        mem[1028] = pte_word(22'h000055, 8'h47);
    end

    // ------------------------------
    // APB response
    // ------------------------------
    assign in_range = (apb_req_i.paddr[PLEN-1:13] == 21'd8);
    assign word_idx = apb_req_i.paddr[12:2];

    assign apb_rsp_o.pready  = apb_req_i.psel && apb_req_i.penable && (wait_q == 2'd0);
    assign apb_rsp_o.prdata  = in_range ? mem[word_idx] : 32'h0;
    assign apb_rsp_o.pslverr = !in_range;

    // wait states are drawn in the setup phase
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wait_q       <= 2'd0;
            read_count_o <= 0;
        end else if (apb_req_i.psel && !apb_req_i.penable) begin
            wait_q <= 2'($random(seed));
        end else if (apb_req_i.psel && apb_req_i.penable) begin
            if (wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end else begin
                read_count_o <= read_count_o + 1;
            end
        end
    end

endmodule

// ==== design/mmu_top.sv ====
// data-side Sv32 MMU top, joining the TLB, the page table walker and the translation stage
`timescale 1ns/1ps

module mmu_top #(
    parameter int unsigned DTLB_ENTRIES = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  mmu_pkg::lsu_req_t         lsu_req_i,
    input  logic                      enable_translation_i,
    input  mmu_pkg::priv_lvl_e        priv_lvl_i,
    input  logic                      sum_i,
    input  logic                      mxr_i,
    input  logic [mmu_pkg::PPN_W-1:0] satp_ppn_i,
    input  logic                      flush_tlb_i,
    // request cycle
    output logic                      lsu_dtlb_hit_o,
    output logic [mmu_pkg::PPN_W-1:0] lsu_dtlb_ppn_o,
    // one cycle later
    output logic                      lsu_valid_o,
    output logic [mmu_pkg::PLEN-1:0]  lsu_paddr_o,
    output mmu_pkg::exception_t       lsu_exc_o,
    // page table memory
    output mmu_pkg::apb_req_t         apb_req_o,
    input  mmu_pkg::apb_rsp_t         apb_rsp_i
);
    import mmu_pkg::*;

    logic            tlb_hit;
    pte_t            tlb_pte;
    logic            tlb_is_4m;
    tlb_update_t     tlb_update;
    walk_fault_t     walk_fault;
    logic            walk_req;
    logic [VLEN-1:0] walk_vaddr;

    dtlb #(
        .DTLB_ENTRIES ( DTLB_ENTRIES )
    ) i_dtlb (
        .clk_i        ( clk_i                                 ),
        .rst_ni       ( rst_ni                                ),
        .flush_i      ( flush_tlb_i                           ),
        .update_i     ( tlb_update                            ),
        .lookup_vpn_i ( lsu_req_i.vaddr[VLEN-1:PAGE_OFFSET_W] ),
        .hit_o        ( tlb_hit                               ),
        .pte_o        ( tlb_pte                               ),
        .is_4m_o      ( tlb_is_4m                             )
    );

    ptw_fsm i_ptw (
        .clk_i        ( clk_i       ),
        .rst_ni       ( rst_ni      ),
        .walk_req_i   ( walk_req    ),
        .walk_vaddr_i ( walk_vaddr  ),
        .satp_ppn_i   ( satp_ppn_i  ),
        .flush_i      ( flush_tlb_i ),
        .apb_req_o    ( apb_req_o   ),
        .apb_rsp_i    ( apb_rsp_i   ),
        .update_o     ( tlb_update  ),
        .fault_o      ( walk_fault  )
    );

    translate_stage i_translate (
        .clk_i                ( clk_i                ),
        .rst_ni               ( rst_ni               ),
        .lsu_req_i            ( lsu_req_i            ),
        .enable_translation_i ( enable_translation_i ),
        .priv_lvl_i           ( priv_lvl_i           ),
        .sum_i                ( sum_i                ),
        .mxr_i                ( mxr_i                ),
        .hit_i                ( tlb_hit              ),
        .pte_i                ( tlb_pte              ),
        .is_4m_i              ( tlb_is_4m            ),
        .walk_fault_i         ( walk_fault           ),
        .walk_req_o           ( walk_req             ),
        .walk_vaddr_o         ( walk_vaddr           ),
        .lsu_dtlb_hit_o       ( lsu_dtlb_hit_o       ),
        .lsu_dtlb_ppn_o       ( lsu_dtlb_ppn_o       ),
        .lsu_valid_o          ( lsu_valid_o          ),
        .lsu_paddr_o          ( lsu_paddr_o          ),
        .lsu_exc_o            ( lsu_exc_o            )
    );

endmodule

// ==== design/translate_stage.sv ====
// registered translation stage that forms the physical address and raises page and access faults
`timescale 1ns/1ps

module translate_stage (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  mmu_pkg::lsu_req_t         lsu_req_i,
    input  logic                      enable_translation_i,
    input  mmu_pkg::priv_lvl_e        priv_lvl_i,
    input  logic                      sum_i,
    input  logic                      mxr_i,
    input  logic                      hit_i,
    input  mmu_pkg::pte_t             pte_i,
    input  logic                      is_4m_i,
    input  mmu_pkg::walk_fault_t      walk_fault_i,
    output logic                      walk_req_o,
    output logic [mmu_pkg::VLEN-1:0]  walk_vaddr_o,
    output logic                      lsu_dtlb_hit_o,
    output logic [mmu_pkg::PPN_W-1:0] lsu_dtlb_ppn_o,
    output logic                      lsu_valid_o,
    output logic [mmu_pkg::PLEN-1:0]  lsu_paddr_o,
    output mmu_pkg::exception_t       lsu_exc_o
);
    import mmu_pkg::*;

    logic            req_valid_q;
    logic            en_q;
    logic            hit_q;
    walk_fault_t     walk_fault_q;
    logic [VLEN-1:0] vaddr_q;
    logic            is_store_q;
    pte_t            pte_q;
    logic            is_4m_q;
    logic            daccess_err;
    logic            perm_err;

    // ------------------------------
    // request cycle
    // ------------------------------
    // bypass always counts as a hit
    assign lsu_dtlb_hit_o = enable_translation_i ? hit_i : 1'b1;

    always_comb begin
        lsu_dtlb_ppn_o = PPN_W'(lsu_req_i.vaddr[VLEN-1:PAGE_OFFSET_W]);
        if (enable_translation_i) begin
            lsu_dtlb_ppn_o = pte_i.ppn;
            if (is_4m_i) begin
                lsu_dtlb_ppn_o[VPN_W-1:0] = lsu_req_i.vaddr[VLEN-VPN_W-1:PAGE_OFFSET_W];
            end
        end
    end

    // the held request is still present while its fault is reported,
    // so no new walk is started in that cycle
    assign walk_req_o   = lsu_req_i.valid && enable_translation_i && !hit_i
                          && (walk_fault_q == '0);
    assign walk_vaddr_o = lsu_req_i.vaddr;

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_valid_q  <= 1'b0;
            en_q         <= 1'b0;
            hit_q        <= 1'b0;
            walk_fault_q <= '0;
        end else begin
            req_valid_q  <= lsu_req_i.valid;
            en_q         <= enable_translation_i;
            hit_q        <= hit_i;
            walk_fault_q <= walk_fault_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= lsu_req_i.vaddr;
        is_store_q <= lsu_req_i.is_store;
        pte_q      <= pte_i;
        is_4m_q    <= is_4m_i;
    end

    // ------------------------------
    // result cycle
    // ------------------------------
    assign lsu_valid_o = req_valid_q && (!en_q || hit_q || (walk_fault_q != '0));

    always_comb begin
        lsu_paddr_o = PLEN'(vaddr_q);
        if (en_q) begin
            lsu_paddr_o = {pte_q.ppn, vaddr_q[PAGE_OFFSET_W-1:0]};
            // megapage keeps vpn0 from the virtual address
            if (is_4m_q) begin
                lsu_paddr_o[PAGE_OFFSET_W+VPN_W-1:PAGE_OFFSET_W] =
                    vaddr_q[PAGE_OFFSET_W+VPN_W-1:PAGE_OFFSET_W];
            end
        end
    end

    // U pages need SUM in supervisor mode, S pages are closed to user mode
    assign daccess_err = ((priv_lvl_i == PRIV_S) && !sum_i && pte_q.u)
                      || ((priv_lvl_i == PRIV_U) && !pte_q.u);
    // stores need W and D, loads need R or X under MXR
    assign perm_err = daccess_err
                   || (is_store_q ? (!pte_q.w || !pte_q.d)
                                  : !(pte_q.r || (pte_q.x && mxr_i)));

    always_comb begin
        lsu_exc_o.valid = 1'b0;
        lsu_exc_o.cause = is_store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
        lsu_exc_o.tval  = vaddr_q;
        if (req_valid_q && walk_fault_q.access_fault) begin
            lsu_exc_o.valid = 1'b1;
            lsu_exc_o.cause = is_store_q ? STORE_ACCESS_FAULT : LOAD_ACCESS_FAULT;
        end else if (req_valid_q && walk_fault_q.page_fault) begin
            lsu_exc_o.valid = 1'b1;
        end else if (req_valid_q && en_q && hit_q && perm_err) begin
            lsu_exc_o.valid = 1'b1;
        end
    end

    // a walk fault answers the held miss that started the walk
    a_fault_for_miss : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (walk_fault_i != '0) |-> (lsu_req_i.valid && enable_translation_i && !hit_i)
    ) else $error("translate_stage: walk fault without a pending miss");

endmodule

// ==== design/ptw_fsm.sv ====
// two-level Sv32 page table walker that reads entries over APB and refills the data TLB
`timescale 1ns/1ps

module ptw_fsm (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      walk_req_i,
    input  logic [mmu_pkg::VLEN-1:0]  walk_vaddr_i,
    input  logic [mmu_pkg::PPN_W-1:0] satp_ppn_i,
    input  logic                      flush_i,
    output mmu_pkg::apb_req_t         apb_req_o,
    input  mmu_pkg::apb_rsp_t         apb_rsp_i,
    output mmu_pkg::tlb_update_t      update_o,
    output mmu_pkg::walk_fault_t      fault_o
);
    import mmu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        DONE
    } state_e;

    state_e           state_q;
    // 1 while reading the root table
    logic             level_q;
    logic [PPN_W-1:0] base_q;
    logic [VLEN-1:0]  vaddr_q;
    // set by a flush seen during the walk
    logic             flushed_q;
    walk_fault_t      fault_q;
    pte_t             pte_q;
    logic             is_4m_q;

    pte_t             rd_pte;
    logic             leaf;
    logic [VPN_W-1:0] vpn_sel;

    assign rd_pte  = pte_t'(apb_rsp_i.prdata);
    assign leaf    = rd_pte.r || rd_pte.x;
    assign vpn_sel = level_q ? vaddr_q[VLEN-1:VLEN-VPN_W]
                             : vaddr_q[VLEN-VPN_W-1:PAGE_OFFSET_W];

    // ------------------------------
    // APB requester
    // ------------------------------
    assign apb_req_o.psel    = (state_q == SETUP) || (state_q == ACCESS);
    assign apb_req_o.penable = (state_q == ACCESS);
    // base * 4096 + vpn * PTE_BYTES
    assign apb_req_o.paddr   = {base_q, vpn_sel, {$clog2(PTE_BYTES){1'b0}}};

    // ------------------------------
    // walk control
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            level_q   <= 1'b1;
            flushed_q <= 1'b0;
            fault_q   <= '0;
        end else begin
            if (flush_i && (state_q != IDLE)) begin
                flushed_q <= 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (walk_req_i) begin
                        state_q   <= SETUP;
                        level_q   <= 1'b1;
                        flushed_q <= 1'b0;
                        fault_q   <= '0;
                    end
                end
                SETUP: state_q <= ACCESS;
                ACCESS: begin
                    // stays here through wait states
                    if (apb_rsp_i.pready) begin
                        state_q <= DONE;
                        if (apb_rsp_i.pslverr) begin
                            fault_q.access_fault <= 1'b1;
                        end else if (!rd_pte.v || (rd_pte.w && !rd_pte.r)) begin
                            fault_q.page_fault <= 1'b1;
                        end else if (leaf) begin
                            // misaligned megapage counts as a page fault too
                            if (!rd_pte.a || (level_q && (rd_pte.ppn[VPN_W-1:0] != '0))) begin
                                fault_q.page_fault <= 1'b1;
                            end
                        end else if (!level_q) begin
                            // pointer at the last level
                            fault_q.page_fault <= 1'b1;
                        end else begin
                            // descend into the second level table
                            state_q <= SETUP;
                            level_q <= 1'b0;
                        end
                    end
                end
                DONE: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // walk data, loaded at the start and at each pready
    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && walk_req_i) begin
            vaddr_q <= walk_vaddr_i;
            base_q  <= satp_ppn_i;
        end else if ((state_q == ACCESS) && apb_rsp_i.pready) begin
            base_q  <= rd_pte.ppn;
            pte_q   <= rd_pte;
            is_4m_q <= level_q;
        end
    end

    // ------------------------------
    // results
    // ------------------------------
    // refill one cycle after the last pready, dropped after a flush
    assign update_o.valid = (state_q == DONE) && (fault_q == '0) && !flushed_q && !flush_i;
    assign update_o.vpn   = vaddr_q[VLEN-1:PAGE_OFFSET_W];
    assign update_o.pte   = pte_q;
    assign update_o.is_4m = is_4m_q;
    assign fault_o        = (state_q == DONE) ? fault_q : '0;

    // a refill only ever carries a valid, accessed leaf
    a_refill_is_leaf : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        update_o.valid |-> (update_o.pte.v && update_o.pte.a
                            && (update_o.pte.r || update_o.pte.x))
    ) else $error("ptw_fsm: refill of an entry that is not a valid leaf");

    a_paddr_stable : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (apb_req_o.psel && apb_req_o.penable && !apb_rsp_i.pready) |=> $stable(apb_req_o.paddr)
    ) else $error("ptw_fsm: paddr moved while waiting for pready");

endmodule

// ==== design/dtlb.sv ====
// fully associative data TLB, looked up in the request cycle and refilled by the page table walker
`timescale 1ns/1ps

module dtlb #(
    parameter int unsigned DTLB_ENTRIES = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    input  mmu_pkg::tlb_update_t        update_i,
    input  logic [2*mmu_pkg::VPN_W-1:0] lookup_vpn_i,
    output logic                        hit_o,
    output mmu_pkg::pte_t               pte_o,
    output logic                        is_4m_o
);
    import mmu_pkg::*;

    localparam int unsigned IDX_W = $clog2(DTLB_ENTRIES);

    // valid bits are the only state that needs a reset
    logic [DTLB_ENTRIES-1:0] valid_q;
    logic [2*VPN_W-1:0]      vpn_q   [DTLB_ENTRIES];
    pte_t                    pte_q   [DTLB_ENTRIES];
    logic                    is_4m_q [DTLB_ENTRIES];

    // replacement pointer
    logic [IDX_W-1:0]        rr_q;
    logic [DTLB_ENTRIES-1:0] match;

    // ------------------------------
    // lookup
    // ------------------------------
    always_comb begin
        for (int unsigned i = 0; i < DTLB_ENTRIES; i++) begin
            // vpn1 always has to agree
            match[i] = valid_q[i]
                && (vpn_q[i][2*VPN_W-1:VPN_W] == lookup_vpn_i[2*VPN_W-1:VPN_W])
                // megapage ignores vpn0
                && (is_4m_q[i] || (vpn_q[i][VPN_W-1:0] == lookup_vpn_i[VPN_W-1:0]));
        end
    end

    assign hit_o = |match;

    // at most one entry matches, so a priority mux is enough
    always_comb begin
        pte_o   = '0;
        is_4m_o = 1'b0;
        for (int unsigned i = 0; i < DTLB_ENTRIES; i++) begin
            if (match[i]) begin
                pte_o   = pte_q[i];
                is_4m_o = is_4m_q[i];
            end
        end
    end

    // ------------------------------
    // refill and flush
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_i) begin
            // flush wins over a refill in the same cycle
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[rr_q] <= 1'b1;
            if (rr_q == IDX_W'(DTLB_ENTRIES - 1)) begin
                rr_q <= '0;
            end else begin
                rr_q <= rr_q + 1'b1;
            end
        end
    end

    // tag and payload, written with the valid bit above
    always_ff @(posedge clk_i) begin
        if (update_i.valid && !flush_i) begin
            vpn_q[rr_q]   <= update_i.vpn;
            pte_q[rr_q]   <= update_i.pte;
            is_4m_q[rr_q] <= update_i.is_4m;
        end
    end

    // the walker only refills on a miss, so a page never sits in two slots
    a_single_hit : assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0(match)
    ) else $error("dtlb: more than one entry hits");

endmodule

// ==== design/mmu_pkg.sv ====
// shared widths, Sv32 field types, enums and structs for the data MMU and its testbench
package mmu_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    // Sv32 virtual address
    localparam int unsigned VLEN          = 32;
    // 34-bit physical address space
    localparam int unsigned PLEN          = 34;
    localparam int unsigned PPN_W         = 22;
    // one level of the virtual page number
    localparam int unsigned VPN_W         = 10;
    localparam int unsigned PAGE_OFFSET_W = 12;
    // one page table entry in memory
    localparam int unsigned PTE_BYTES     = 4;

    // ------------------------------
    // enums
    // ------------------------------
    // machine mode never reaches the data MMU
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01
    } priv_lvl_e;

    // mcause encodings, limited to the causes this unit can raise
    typedef enum logic [3:0] {
        LOAD_ACCESS_FAULT  = 4'd5,
        STORE_ACCESS_FAULT = 4'd7,
        LOAD_PAGE_FAULT    = 4'd13,
        STORE_PAGE_FAULT   = 4'd15
    } exc_cause_e;

    // ------------------------------
    // structs
    // ------------------------------
    // laid out as in memory, so prdata casts straight onto it
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // refill from the walker into the TLB
    typedef struct packed {
        logic               valid;
        logic [2*VPN_W-1:0] vpn;
        pte_t               pte;
        // leaf found at level 1
        logic               is_4m;
    } tlb_update_t;

    // one-cycle fault result at the end of a walk
    typedef struct packed {
        logic page_fault;
        logic access_fault;
    } walk_fault_t;

    typedef struct packed {
        logic            valid;
        exc_cause_e      cause;
        logic [VLEN-1:0] tval;
    } exception_t;

    // translation request from the load/store unit
    typedef struct packed {
        logic            valid;
        logic [VLEN-1:0] vaddr;
        logic            is_store;
    } lsu_req_t;

    // APB, read only, so no pwrite and no pwdata
    typedef struct packed {
        logic            psel;
        logic            penable;
        logic [PLEN-1:0] paddr;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

endpackage
